// ==== common/conv_pkg.sv ====
package conv_pkg;

  // ####################################################################
  // Widths
  // ####################################################################
  localparam int DATA_W  = 32;  // Memory word
  localparam int IDX_W   = 16;  // Output position
  localparam int LANES   = 4;
  localparam int WCODE_W = 2;
  localparam int WVAL_W  = 10;
  localparam int ACC_W   = 24;  // Lane sums as seen by the result stage

  typedef logic signed [7:0]        act_t;
  typedef logic [WCODE_W-1:0]       wcode_t;
  typedef logic signed [WVAL_W-1:0] wval_t;

  // Weight codes
  localparam wcode_t WC_ZERO = 2'd0;
  localparam wcode_t WC_POS  = 2'd1;  // +pos_w
  localparam wcode_t WC_NEG1 = 2'd2;  // -neg_w1
  localparam wcode_t WC_NEG2 = 2'd3;  // -neg_w2

  // Layer setup, loaded once per start
  typedef struct packed {
    logic [IDX_W-1:0]  n_out;
    logic [3:0]        k_size;
    logic [7:0]        pos_w;
    logic [7:0]        neg_w1;
    logic [7:0]        neg_w2;
    logic [4:0]        shift;
    act_t [LANES-1:0]  bias;
  } layer_cfg_t;

endpackage

// ==== common/tap_if.sv ====
interface tap_if import conv_pkg::*; #(
  parameter int WGT_W = WCODE_W  // Raw codes or decoded multipliers
) ();

  logic                        valid;
  logic                        first;  // First tap of an output
  logic                        last;   // Last tap of an output
  logic                        fin;    // Last tap of the whole layer
  logic [IDX_W-1:0]            idx;
  act_t                        act;
  logic [LANES-1:0][WGT_W-1:0] wgt;

  modport src (
    output valid, first, last, fin, idx, act, wgt
  );

  modport dst (
    input valid, first, last, fin, idx, act, wgt
  );

endinterface

// ==== conv_core/lane_mac.sv ====
module lane_mac import conv_pkg::*; #(
  parameter int LANE = 0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  layer_cfg_t              cfg,
  tap_if.dst                      tap,
  output logic signed [ACC_W-1:0] acc
);

  logic signed [ACC_W-1:0] prod;
  logic signed [ACC_W-1:0] base;
  act_t                    bias;

  assign bias = cfg.bias[LANE];

  // Both operands signed, extended to the accumulator width
  assign prod = tap.act * $signed(tap.wgt[LANE]);

  // New output starts from its bias
  always_comb begin
    if (tap.first) begin
      base = {{(ACC_W-8){bias[7]}}, bias};
    end else begin
      base = acc;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      acc <= '0;
    end else if (tap.valid) begin
      acc <= base + prod;
    end
  end

endmodule

// ==== conv_core/out_pack.sv ====
module out_pack import conv_pkg::*; #(
  parameter int ADDR_W = 16
) (
  input  logic                    clk,
  input  logic                    rst,
  input  layer_cfg_t              cfg,
  tap_if.dst                      tap,
  input  logic signed [ACC_W-1:0] acc0,
  input  logic signed [ACC_W-1:0] acc1,
  input  logic signed [ACC_W-1:0] acc2,
  input  logic signed [ACC_W-1:0] acc3,
  output logic [ADDR_W-1:0]       out_addr,
  output logic [DATA_W-1:0]       out_wdata,
  output logic [3:0]              out_we,
  output logic                    finish
);

  localparam logic signed [ACC_W-1:0] SAT_MAX = 127;
  localparam logic signed [ACC_W-1:0] SAT_MIN = -128;

  logic signed [ACC_W-1:0] acc [LANES];
  logic signed [ACC_W-1:0] sh  [LANES];
  logic [DATA_W-1:0]       word;
  logic                    last_q;
  logic                    fin_q;
  logic [IDX_W-1:0]        idx_q;

  assign acc = '{acc0, acc1, acc2, acc3};

  // Shift and clamp to a signed byte
  always_comb begin
    for (int j = 0; j < LANES; j++) begin
      sh[j] = acc[j] >>> cfg.shift;
      if (sh[j] > SAT_MAX) word[8*j +: 8] = 8'h7f;
      else if (sh[j] < SAT_MIN) word[8*j +: 8] = 8'h80;
      else word[8*j +: 8] = sh[j][7:0];
    end
  end

  // Lane sums settle one cycle after the last tap
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      last_q <= 1'b0;
      fin_q  <= 1'b0;
      out_we <= '0;
      finish <= 1'b0;
    end else begin
      last_q <= tap.valid & tap.last;
      fin_q  <= tap.valid & tap.last & tap.fin;
      out_we <= {4{last_q}};
      finish <= fin_q;
    end
  end

  always_ff @(posedge clk) begin
    idx_q <= tap.idx;
    if (last_q) begin
      out_addr  <= ADDR_W'(idx_q);
      out_wdata <= word;
    end
  end

  // Layer end only on an output boundary
  a_fin_on_last: assert property (@(posedge clk) disable iff (!rst)
    tap.valid && tap.fin |-> tap.last);

endmodule

// ==== conv_core/weight_decode.sv ====
module weight_decode import conv_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  layer_cfg_t cfg,
  tap_if.dst         raw,
  tap_if.src         dec
);

  wval_t dec_w [LANES];

  always_comb begin
    for (int j = 0; j < LANES; j++) begin
      case (wcode_t'(raw.wgt[j]))
        WC_POS:  dec_w[j] = wval_t'({2'b00, cfg.pos_w});
        WC_NEG1: dec_w[j] = -wval_t'({2'b00, cfg.neg_w1});
        WC_NEG2: dec_w[j] = -wval_t'({2'b00, cfg.neg_w2});
        default: dec_w[j] = '0;  // WC_ZERO
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) dec.valid <= 1'b0;
    else dec.valid <= raw.valid;
  end

  always_ff @(posedge clk) begin
    dec.first <= raw.first;
    dec.last  <= raw.last;
    dec.fin   <= raw.fin;
    dec.idx   <= raw.idx;
    dec.act   <= raw.act;
    for (int j = 0; j < LANES; j++) dec.wgt[j] <= dec_w[j];
  end

  // Next output starts right after the last tap
  a_no_gap: assert property (@(posedge clk) disable iff (!rst)
    raw.valid && raw.last && !raw.fin |=> raw.valid && raw.first);

endmodule

// ==== hw/conv_ctrl.sv ====
module conv_ctrl import conv_pkg::*; #(
  parameter int ADDR_W = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  output logic [ADDR_W-1:0] p_addr,
  input  logic [DATA_W-1:0] p_rdata,
  output logic [ADDR_W-1:0] in_addr,
  input  logic [DATA_W-1:0] in_rdata,
  output logic [ADDR_W-1:0] w_addr,
  input  logic [DATA_W-1:0] w_rdata,
  output logic [ADDR_W-1:0] b_addr,
  input  logic [DATA_W-1:0] b_rdata,
  input  logic              finish,
  output layer_cfg_t        cfg,
  tap_if.src                tap
);

  typedef enum logic [1:0] {S_IDLE, S_LOAD, S_STREAM, S_WAIT} state_t;

  state_t           state;
  logic [1:0]       ld_cnt;
  logic [IDX_W-1:0] n_cnt;
  logic [3:0]       k_cnt;
  logic             k_end;
  logic             n_end;
  logic             vld_q;
  logic             first_q;
  logic             last_q;
  logic             fin_q;
  logic [IDX_W-1:0] idx_q;

  assign k_end = (k_cnt == cfg.k_size - 4'd1);
  assign n_end = (n_cnt == cfg.n_out - IDX_W'(1));

  // Word 0 then word 1 of the parameter memory
  assign p_addr  = (ld_cnt == 2'd1) ? ADDR_W'(1) : '0;
  assign b_addr  = '0;  // One bias word per layer
  assign w_addr  = ADDR_W'(k_cnt);
  assign in_addr = ADDR_W'(n_cnt) + ADDR_W'(k_cnt);

  // ####################################################################
  // Sequencer
  // ####################################################################
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state  <= S_IDLE;
      ld_cnt <= '0;
      n_cnt  <= '0;
      k_cnt  <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state  <= S_LOAD;
            ld_cnt <= '0;
          end
        end
        S_LOAD: begin
          ld_cnt <= ld_cnt + 2'd1;
          if (ld_cnt == 2'd3) begin
            state <= S_STREAM;
            n_cnt <= '0;
            k_cnt <= '0;
          end
        end
        S_STREAM: begin
          if (k_end) begin
            k_cnt <= '0;
            if (n_end) state <= S_WAIT;
            else n_cnt <= n_cnt + IDX_W'(1);
          end else begin
            k_cnt <= k_cnt + 4'd1;
          end
        end
        S_WAIT: if (finish) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Config capture, data lags the address by one cycle
  always_ff @(posedge clk) begin
    idx_q <= n_cnt;
    if (state == S_LOAD) begin
      case (ld_cnt)
        2'd1: begin
          cfg.n_out  <= p_rdata[15:0];
          cfg.k_size <= p_rdata[19:16];
        end
        2'd2: begin
          cfg.pos_w  <= p_rdata[7:0];
          cfg.neg_w1 <= p_rdata[15:8];
          cfg.neg_w2 <= p_rdata[23:16];
          cfg.shift  <= p_rdata[28:24];
        end
        2'd3: begin
          for (int j = 0; j < LANES; j++) cfg.bias[j] <= b_rdata[8*j +: 8];
        end
        default: ;
      endcase
    end
  end

  // ####################################################################
  // Tap sideband, aligned with the read data
  // ####################################################################
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      vld_q   <= 1'b0;
      first_q <= 1'b0;
      last_q  <= 1'b0;
      fin_q   <= 1'b0;
    end else begin
      vld_q   <= (state == S_STREAM);
      first_q <= (k_cnt == 4'd0);
      last_q  <= k_end;
      fin_q   <= k_end && n_end;
    end
  end

  assign tap.valid = vld_q;
  assign tap.first = first_q;
  assign tap.last  = last_q;
  assign tap.fin   = fin_q;
  assign tap.idx   = idx_q;
  assign tap.act   = in_rdata[7:0];

  always_comb begin
    for (int j = 0; j < LANES; j++) tap.wgt[j] = w_rdata[8*j +: WCODE_W];
  end

  a_cfg_nonzero: assert property (@(posedge clk) disable iff (!rst)
    (state == S_LOAD && ld_cnt == 2'd1) |=> (cfg.n_out != '0 && cfg.k_size != '0));

  a_start_idle: assert property (@(posedge clk) disable iff (!rst)
    start |-> state == S_IDLE);

endmodule

// ==== hw/conv_top.sv ====
module conv_top import conv_pkg::*; #(
  parameter int ADDR_W = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  output logic              finish,
  output logic [ADDR_W-1:0] p_addr,
  input  logic [DATA_W-1:0] p_rdata,
  output logic [ADDR_W-1:0] in_addr,
  input  logic [DATA_W-1:0] in_rdata,
  output logic [ADDR_W-1:0] w_addr,
  input  logic [DATA_W-1:0] w_rdata,
  output logic [ADDR_W-1:0] b_addr,
  input  logic [DATA_W-1:0] b_rdata,
  output logic [ADDR_W-1:0] out_addr,
  output logic [DATA_W-1:0] out_wdata,
  output logic [3:0]        out_we
);

  layer_cfg_t              cfg;
  logic signed [ACC_W-1:0] acc [LANES];

  tap_if #(.WGT_W(WCODE_W)) raw_tap ();
  tap_if #(.WGT_W(WVAL_W))  dec_tap ();

  // ####################################################################
  // Sequencer and decode
  // ####################################################################
  conv_ctrl #(.ADDR_W(ADDR_W)) i_ctrl (
    .clk(clk), .rst(rst), .start(start),
    .p_addr(p_addr), .p_rdata(p_rdata),
    .in_addr(in_addr), .in_rdata(in_rdata),
    .w_addr(w_addr), .w_rdata(w_rdata),
    .b_addr(b_addr), .b_rdata(b_rdata),
    .finish(finish), .cfg(cfg), .tap(raw_tap)
  );

  weight_decode i_decode (
    .clk(clk), .rst(rst), .cfg(cfg), .raw(raw_tap), .dec(dec_tap)
  );

  // ####################################################################
  // Lanes and result
  // ####################################################################
  for (genvar j = 0; j < LANES; j++) begin : g_lane
    lane_mac #(.LANE(j)) i_lane (
      .clk(clk), .rst(rst), .cfg(cfg), .tap(dec_tap), .acc(acc[j])
    );
  end

  out_pack #(.ADDR_W(ADDR_W)) i_pack (
    .clk(clk), .rst(rst), .cfg(cfg), .tap(dec_tap),
    .acc0(acc[0]), .acc1(acc[1]), .acc2(acc[2]), .acc3(acc[3]),
    .out_addr(out_addr), .out_wdata(out_wdata), .out_we(out_we),
    .finish(finish)
  );

endmodule

// ==== list.f ====
common/conv_pkg.sv
common/tap_if.sv
hw/conv_ctrl.sv
conv_core/weight_decode.sv
conv_core/lane_mac.sv
conv_core/out_pack.sv
hw/conv_top.sv
sim/mem_model.sv
sim/tb_conv.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log \
  && verilator --binary --timing --assert -Wno-fatal --top-module tb_conv -f list.f \
  && ./obj_dir/Vtb_conv | tee sim.log \
  && grep -qx "All tests passed" sim.log \
  || { echo "Simulation failed"; exit 1; }
echo "Simulation passed"

// ==== sim/mem_model.sv ====
module mem_model #(
  parameter int ADDR_W = 16,
  parameter int DATA_W = 32,
  parameter int DEPTH  = 64
) (
  input  logic                clk,
  input  logic [ADDR_W-1:0]   addr,
  output logic [DATA_W-1:0]   rdata,
  input  logic [DATA_W/8-1:0] we,     // Byte strobes, tied off when read only
  input  logic [DATA_W-1:0]   wdata
);

  localparam int AW = $clog2(DEPTH);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [DATA_W-1:0] rd_q = '0;
  logic [AW-1:0]     a;

  assign a = addr[AW-1:0];  // Upper address bits ignored

  // One cycle read latency, read before write
  always @(posedge clk) begin
    for (int b = 0; b < DATA_W/8; b++) begin
      if (we[b]) mem[a][8*b +: 8] <= wdata[8*b +: 8];
    end
    rd_q <= mem[a];
  end

  assign rdata = rd_q;

endmodule

// ==== sim/tb_conv.sv ====
module tb_conv import conv_pkg::*; ();

  localparam int ADDR_W = 16;
  localparam int MEM_D  = 64;

  logic              clk = 1'b0;
  logic              rst;
  logic              start;
  logic              finish;
  logic [ADDR_W-1:0] p_addr, in_addr, w_addr, b_addr, out_addr;
  logic [DATA_W-1:0] p_rdata, in_rdata, w_rdata, b_rdata, out_wdata;
  logic [3:0]        out_we;

  // Layer under test and its reference results
  int          n_out, k_size, pos_w, neg_w1, neg_w2, shift;
  int          bias [LANES];
  int          act [MEM_D];
  logic [1:0]  code [8][LANES];
  logic [31:0] exp_word [MEM_D];

  logic        busy;
  int          wr_cnt;
  logic [63:0] written;  // One bit per output address
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          fail_cnt = 0;
  int          budget = 200;  // Cycles, grows with each layer
  int          cycles = 0;

  always #10 clk = ~clk;

  conv_top #(.ADDR_W(ADDR_W)) i_dut (
    .clk(clk), .rst(rst), .start(start), .finish(finish),
    .p_addr(p_addr), .p_rdata(p_rdata), .in_addr(in_addr), .in_rdata(in_rdata),
    .w_addr(w_addr), .w_rdata(w_rdata), .b_addr(b_addr), .b_rdata(b_rdata),
    .out_addr(out_addr), .out_wdata(out_wdata), .out_we(out_we)
  );

  mem_model #(.ADDR_W(ADDR_W), .DEPTH(MEM_D)) i_pmem (
    .clk(clk), .addr(p_addr), .rdata(p_rdata), .we(4'h0), .wdata('0));
  mem_model #(.ADDR_W(ADDR_W), .DEPTH(MEM_D)) i_imem (
    .clk(clk), .addr(in_addr), .rdata(in_rdata), .we(4'h0), .wdata('0));
  mem_model #(.ADDR_W(ADDR_W), .DEPTH(MEM_D)) i_wmem (
    .clk(clk), .addr(w_addr), .rdata(w_rdata), .we(4'h0), .wdata('0));
  mem_model #(.ADDR_W(ADDR_W), .DEPTH(MEM_D)) i_bmem (
    .clk(clk), .addr(b_addr), .rdata(b_rdata), .we(4'h0), .wdata('0));
  mem_model #(.ADDR_W(ADDR_W), .DEPTH(MEM_D)) i_omem (
    .clk(clk), .addr(out_addr), .rdata(), .we(out_we), .wdata(out_wdata));

  // ####################################################################
  // Scoreboard and checks
  // ####################################################################
  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      busy    <= 1'b0;
      wr_cnt  <= 0;
      written <= '0;
    end else if (start) begin
      busy    <= 1'b1;
      wr_cnt  <= 0;
      written <= '0;
    end else begin
      if (finish) busy <= 1'b0;
      if (|out_we) begin
        wr_cnt <= wr_cnt + 1;
        written[out_addr[5:0]] <= 1'b1;
      end
    end
  end

  always @(posedge clk) cycles <= cycles + 1;

  a_we_busy: assert property (@(negedge clk) disable iff (!rst)
    ((|out_we) || finish) |-> busy)
    else begin
      $display("Write or finish at %0t while no layer was running", $time);
      err_cnt++;
    end

  a_strobe: assert property (@(negedge clk) disable iff (!rst)
    (|out_we) |-> out_we == 4'hf)
    else begin
      $display("** Error at %0t: out_we expected f, got %h", $time, out_we);
      err_cnt++;
    end

  a_addr: assert property (@(negedge clk) disable iff (!rst)
    (|out_we) |-> int'(out_addr) < n_out)
    else begin
      $display("** Error at %0t: out_addr expected below %0d, got %0d", $time, n_out, out_addr);
      err_cnt++;
    end

  a_data: assert property (@(negedge clk) disable iff (!rst)
    (|out_we) |-> out_wdata == exp_word[out_addr[5:0]])
    else begin
      $display("** Error at %0t: out_wdata at %0d expected %h, got %h",
               $time, out_addr, exp_word[out_addr[5:0]], out_wdata);
      err_cnt++;
    end

  a_once: assert property (@(negedge clk) disable iff (!rst)
    (|out_we) |-> !written[out_addr[5:0]])
    else begin
      $display("Address %0d written twice at %0t", out_addr, $time);
      err_cnt++;
    end

  a_finish: assert property (@(negedge clk) disable iff (!rst)
    finish |-> (|out_we) && wr_cnt == n_out - 1)
    else begin
      $display("finish at %0t came with write %0d of %0d", $time, wr_cnt + 1, n_out);
      err_cnt++;
    end

  initial begin : watchdog
    while (cycles <= budget) @(posedge clk);
    $display("Timeout: no finish after %0d cycles", cycles);
    $display("Some tests failed");
    $finish;
  end

  // ####################################################################
  // Reference model and layer handling
  // ####################################################################
  function automatic int weight_value(logic [1:0] c);
    case (c)
      WC_POS:  return pos_w;
      WC_NEG1: return -neg_w1;
      WC_NEG2: return -neg_w2;
      default: return 0;
    endcase
  endfunction

  function automatic logic [7:0] clamp_byte(int s);
    if (s > 127) return 8'h7f;
    if (s < -128) return 8'h80;
    return 8'(s);
  endfunction

  task automatic randomize_layer(input int n, input int k);
    n_out  = n;
    k_size = k;
    pos_w  = int'($urandom % 256);
    neg_w1 = int'($urandom % 256);
    neg_w2 = int'($urandom % 256);
    shift  = int'($urandom % 13);
    for (int j = 0; j < LANES; j++) bias[j] = int'($urandom % 256) - 128;
    for (int i = 0; i < MEM_D; i++) act[i] = int'($urandom % 256) - 128;
    for (int t = 0; t < 8; t++) begin
      for (int j = 0; j < LANES; j++) code[t][j] = 2'($urandom % 4);
    end
  endtask

  // Unused bits get random junk
  task automatic load_layer();
    logic [31:0] w;
    int          s;
    w = $urandom;
    w[15:0]  = 16'(n_out);
    w[19:16] = 4'(k_size);
    i_pmem.mem[0] <= w;
    w = $urandom;
    w[7:0]   = 8'(pos_w);
    w[15:8]  = 8'(neg_w1);
    w[23:16] = 8'(neg_w2);
    w[28:24] = 5'(shift);
    i_pmem.mem[1] <= w;
    for (int j = 0; j < LANES; j++) w[8*j +: 8] = 8'(bias[j]);
    i_bmem.mem[0] <= w;
    for (int i = 0; i < MEM_D; i++) begin
      w = $urandom;
      w[7:0] = 8'(act[i]);
      i_imem.mem[i] <= w;
    end
    for (int t = 0; t < 8; t++) begin
      w = $urandom;
      for (int j = 0; j < LANES; j++) w[8*j +: 2] = code[t][j];
      i_wmem.mem[t] <= w;
    end
    for (int n = 0; n < n_out; n++) begin
      for (int j = 0; j < LANES; j++) begin
        s = bias[j];
        for (int t = 0; t < k_size; t++) s += act[n+t] * weight_value(code[t][j]);
        exp_word[n][8*j +: 8] = clamp_byte(s >>> shift);
      end
    end
    budget += 20 * (n_out * k_size + 10);
  endtask

  task automatic run_layer();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    while (!finish) @(negedge clk);
    @(negedge clk);  // Last write has landed
    for (int n = 0; n < n_out; n++) begin
      assert (i_omem.mem[n] == exp_word[n])
      else begin
        $display("** Error at %0t: out_mem[%0d] expected %h, got %h",
                 $time, n, exp_word[n], i_omem.mem[n]);
        err_cnt++;
      end
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
      $display("%s: ok", name);
    end else begin
      fail_cnt++;
      $display("%s: FAIL with %0d errors", name, err_cnt - err_before);
    end
  endtask

  // ####################################################################
  // Stimulus
  // ####################################################################
  initial begin
    int e0;
    void'($urandom(32'h7923_5e5b));
    rst   = 1'b0;
    start = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b1;

    e0 = err_cnt;
    randomize_layer(16, 1);
    pos_w = 1;
    shift = 0;
    for (int j = 0; j < LANES; j++) begin
      bias[j]    = 0;
      code[0][j] = WC_POS;
    end
    load_layer();
    run_layer();
    report_test("identity layer", e0);

    e0 = err_cnt;
    randomize_layer(12, 8);
    pos_w  = 3;
    neg_w1 = 11;
    neg_w2 = 29;
    shift  = 4;
    for (int t = 0; t < 8; t++) begin
      for (int j = 0; j < LANES; j++) code[t][j] = 2'((t + j) % 4);  // All codes per lane
    end
    load_layer();
    run_layer();
    report_test("weight codes", e0);

    e0 = err_cnt;
    randomize_layer(16, 4);
    pos_w  = 255;
    neg_w1 = 200;
    neg_w2 = 255;
    shift  = 0;
    for (int j = 0; j < LANES; j++) bias[j] = -1 - int'($urandom % 128);
    for (int i = 0; i < MEM_D; i++) begin
      act[i] = (i < 8) ? 64 + int'($urandom % 64) : -64 - int'($urandom % 65);
    end
    for (int t = 0; t < 8; t++) begin
      code[t][0] = WC_POS;
      code[t][1] = WC_NEG1;
      code[t][2] = WC_ZERO;  // Output is the bias alone
      code[t][3] = WC_NEG2;
    end
    load_layer();
    run_layer();
    report_test("saturation", e0);

    e0 = err_cnt;
    repeat (4) begin
      randomize_layer(1 + int'($urandom % 16), 1 + int'($urandom % 8));
      load_layer();
      run_layer();
    end
    report_test("shift and bias", e0);

    e0 = err_cnt;
    repeat (6) begin
      randomize_layer(1 + int'($urandom % 20), 1 + int'($urandom % 8));
      load_layer();
      run_layer();
    end
    report_test("back-to-back layers", e0);

    $display("%0d tests, %0d ok, %0d failing, %0d errors",
             test_cnt, test_cnt - fail_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) $display("All tests passed");
    else $display("Some tests failed");
    $finish;
  end

endmodule
